// ==== rvIsaPkg.sv ====
package rvIsaPkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] wordT;
    typedef logic [4:0]      regIdxT;

    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSub  = 4'b0001,
        aluAnd  = 4'b0010,
        aluOr   = 4'b0011,
        aluXor  = 4'b0100,
        aluSll  = 4'b0101,
        aluSrl  = 4'b0110,
        aluSra  = 4'b0111,
        aluSlt  = 4'b1000,
        aluSltu = 4'b1001
    } aluOpT;

    // Opcode bits 6..2, the low two bits are always 11
    localparam logic [4:0] opOp      = 5'b01100;
    localparam logic [4:0] opOpImm   = 5'b00100;
    localparam logic [4:0] opLoad    = 5'b00000;
    localparam logic [4:0] opStore   = 5'b01000;
    localparam logic [4:0] opBranch  = 5'b11000;
    localparam logic [4:0] opJal     = 5'b11011;
    localparam logic [4:0] opJalr    = 5'b11001;
    localparam logic [4:0] opLui     = 5'b01101;
    localparam logic [4:0] opAuipc   = 5'b00101;
    localparam logic [4:0] opMiscMem = 5'b00011;
    localparam logic [4:0] opSystem  = 5'b11100;

    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    localparam logic [2:0] f3Lb  = 3'b000;
    localparam logic [2:0] f3Lh  = 3'b001;
    localparam logic [2:0] f3Lw  = 3'b010;
    localparam logic [2:0] f3Lbu = 3'b100;
    localparam logic [2:0] f3Lhu = 3'b101;
    localparam logic [2:0] f3Sb  = 3'b000;
    localparam logic [2:0] f3Sh  = 3'b001;
    localparam logic [2:0] f3Sw  = 3'b010;

endpackage

// ==== rvCtrlPkg.sv ====
package rvCtrlPkg;

    // Source of the register write-back data
    typedef enum logic [1:0] {
        wbAlu     = 2'd0,
        wbImm     = 2'd1, // LUI
        wbPcImm   = 2'd2, // AUIPC
        wbPcPlus4 = 2'd3  // Link address of JAL and JALR
    } wbSelT;

    // Same encoding as funct3 bits 1..0 of loads and stores
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } sizeT;

    typedef logic [3:0] byteEnT; // One bit per byte lane

endpackage

// ==== ctrlIf.sv ====
interface ctrlIf;
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    aluOpT aluCtrl;
    logic  aluImm;     // Operand B from the immediate
    logic  aluToPc;    // Jump target from the ALU
    logic  branch;     // Next PC is pc + imm
    sizeT  loadSel;
    sizeT  maskSel;
    logic  memToReg;
    logic  memWr;
    wbSelT regDataSel;
    logic  regWr;
    logic  uext;       // Zero-extend loaded data

    modport ctrlSrc (
        output aluCtrl, aluImm, aluToPc, branch, loadSel, maskSel,
        output memToReg, memWr, regDataSel, regWr, uext
    );

    modport ctrlSnk (
        input aluCtrl, aluImm, aluToPc, branch, loadSel, maskSel,
        input memToReg, memWr, regDataSel, regWr, uext
    );

endinterface

// ==== controller.sv ====
module controller (
    input  rvIsaPkg::wordT instruction,
    input  logic           aluZero,
    ctrlIf.ctrlSrc         ctrl
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       jump;      // JAL or JALR
    logic       condBr;    // Conditional branch
    logic       brOnZero;  // Taken when the ALU result is zero

    assign opcode   = instruction[6:2];
    assign funct3   = instruction[14:12];
    assign funct7b5 = instruction[30];

    always_comb begin
        ctrl.aluCtrl    = aluAdd;
        ctrl.aluImm     = 1'b0;
        ctrl.aluToPc    = 1'b0;
        ctrl.loadSel    = sizeT'(funct3[1:0]);
        ctrl.maskSel    = sizeT'(funct3[1:0]);
        ctrl.memToReg   = 1'b0;
        ctrl.memWr      = 1'b0;
        ctrl.regDataSel = wbAlu;
        ctrl.regWr      = 1'b0;
        ctrl.uext       = funct3[2];
        jump            = 1'b0;
        condBr          = 1'b0;
        brOnZero        = 1'b0;

        case (opcode)
            opOp, opOpImm: begin
                ctrl.aluImm = (opcode == opOpImm);
                ctrl.regWr  = 1'b1;
                case (funct3)
                    3'b000: begin
                        // SUB only in register form
                        if (opcode == opOp && funct7b5) begin
                            ctrl.aluCtrl = aluSub;
                        end else begin
                            ctrl.aluCtrl = aluAdd;
                        end
                    end
                    3'b001: ctrl.aluCtrl = aluSll;
                    3'b010: ctrl.aluCtrl = aluSlt;
                    3'b011: ctrl.aluCtrl = aluSltu;
                    3'b100: ctrl.aluCtrl = aluXor;
                    3'b101: ctrl.aluCtrl = funct7b5 ? aluSra : aluSrl;
                    3'b110: ctrl.aluCtrl = aluOr;
                    default: ctrl.aluCtrl = aluAnd;
                endcase
            end
            opLoad: begin
                ctrl.aluImm   = 1'b1; // Address rs1 + imm
                ctrl.memToReg = 1'b1;
                ctrl.regWr    = 1'b1;
            end
            opStore: begin
                ctrl.aluImm = 1'b1;
                ctrl.memWr  = 1'b1;
            end
            opBranch: begin
                condBr = 1'b1;
                case (funct3)
                    f3Beq: begin
                        ctrl.aluCtrl = aluSub;
                        brOnZero     = 1'b1;
                    end
                    f3Bne: ctrl.aluCtrl = aluSub;
                    f3Blt: ctrl.aluCtrl = aluSlt;
                    f3Bge: begin
                        ctrl.aluCtrl = aluSlt;
                        brOnZero     = 1'b1;
                    end
                    f3Bltu: ctrl.aluCtrl = aluSltu;
                    f3Bgeu: begin
                        ctrl.aluCtrl = aluSltu;
                        brOnZero     = 1'b1;
                    end
                    default: condBr = 1'b0; // Reserved funct3, never taken
                endcase
            end
            opJalr: begin
                ctrl.aluImm     = 1'b1;
                ctrl.aluToPc    = 1'b1;
                ctrl.regDataSel = wbPcPlus4;
                ctrl.regWr      = 1'b1;
                jump            = 1'b1;
            end
            opJal: begin
                ctrl.regDataSel = wbPcPlus4;
                ctrl.regWr      = 1'b1;
                jump            = 1'b1;
            end
            opLui: begin
                ctrl.regDataSel = wbImm;
                ctrl.regWr      = 1'b1;
            end
            opAuipc: begin
                ctrl.regDataSel = wbPcImm;
                ctrl.regWr      = 1'b1;
            end
            opMiscMem, opSystem: begin
                // FENCE, ECALL, EBREAK and CSR accesses do nothing here
            end
            default: begin
            end
        endcase
    end

    // Kept apart from the decode block, aluZero depends on aluCtrl
    assign ctrl.branch = jump | (condBr & (aluZero ~^ brOnZero));

endmodule

// ==== immGen.sv ====
module immGen (
    input  rvIsaPkg::wordT instruction,
    output rvIsaPkg::wordT imm
);
    import rvIsaPkg::*;

    logic [4:0] opcode;
    logic       sgn;

    assign opcode = instruction[6:2];
    assign sgn    = instruction[31];

    always_comb begin
        case (opcode)
            opOpImm, opLoad, opJalr: begin // I format
                imm = {{20{sgn}}, instruction[31:20]};
            end
            opStore: begin // S format
                imm = {{20{sgn}}, instruction[31:25], instruction[11:7]};
            end
            opBranch: begin // B format
                imm = {{19{sgn}}, sgn, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            end
            opLui, opAuipc: begin // U format
                imm = {instruction[31:12], 12'b0};
            end
            opJal: begin // J format
                imm = {{11{sgn}}, sgn, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// ==== execStage.sv ====
module execStage #(
    parameter rvIsaPkg::wordT resetPc = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             step,
    input  rvIsaPkg::wordT   instruction,
    input  rvIsaPkg::wordT   rs1Data,
    input  rvIsaPkg::wordT   rs2Data,
    input  rvIsaPkg::wordT   memRdData,
    input  rvIsaPkg::wordT   imm,
    ctrlIf.ctrlSnk           ctrl,
    output logic             aluZero,
    output rvIsaPkg::wordT   pc,
    output logic             rdWrEn,
    output rvIsaPkg::regIdxT rdAddr,
    output rvIsaPkg::wordT   rdData,
    output rvIsaPkg::wordT   memAddr,
    output logic             memWrEn,
    output rvCtrlPkg::byteEnT memByteEn,
    output rvIsaPkg::wordT   memWrData
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    wordT       opB;
    wordT       aluRes;
    logic [4:0] shamt;
    logic [1:0] offset;     // Byte offset within the word
    logic [7:0] ldByte;
    logic [15:0] ldHalf;
    wordT       ldData;
    wordT       wbData;
    wordT       pcPlus4;
    wordT       pcImm;
    wordT       nextPc;

    assign opB   = ctrl.aluImm ? imm : rs2Data;
    assign shamt = opB[4:0];

    always_comb begin
        case (ctrl.aluCtrl)
            aluAdd:  aluRes = rs1Data + opB;
            aluSub:  aluRes = rs1Data - opB;
            aluAnd:  aluRes = rs1Data & opB;
            aluOr:   aluRes = rs1Data | opB;
            aluXor:  aluRes = rs1Data ^ opB;
            aluSll:  aluRes = rs1Data << shamt;
            aluSrl:  aluRes = rs1Data >> shamt;
            aluSra:  aluRes = $signed(rs1Data) >>> shamt;
            aluSlt:  aluRes = wordT'($signed(rs1Data) < $signed(opB));
            aluSltu: aluRes = wordT'(rs1Data < opB);
            default: aluRes = '0;
        endcase
    end

    assign aluZero = (aluRes == '0); // Feeds the branch decision
    assign memAddr = aluRes;
    assign offset  = aluRes[1:0];

    // Load lane select and extension
    assign ldByte = memRdData[{offset, 3'b000} +: 8];
    assign ldHalf = offset[1] ? memRdData[31:16] : memRdData[15:0];

    always_comb begin
        case (ctrl.loadSel)
            sizeByte: ldData = ctrl.uext ? {24'b0, ldByte} : {{24{ldByte[7]}}, ldByte};
            sizeHalf: ldData = ctrl.uext ? {16'b0, ldHalf} : {{16{ldHalf[15]}}, ldHalf};
            default:  ldData = memRdData;
        endcase
    end

    // Store data replicated over all lanes, byte enables pick the lanes
    always_comb begin
        case (ctrl.maskSel)
            sizeByte: begin
                memWrData = {4{rs2Data[7:0]}};
                memByteEn = byteEnT'(4'b0001 << offset);
            end
            sizeHalf: begin
                memWrData = {2{rs2Data[15:0]}};
                memByteEn = offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                memWrData = rs2Data;
                memByteEn = 4'b1111;
            end
        endcase
    end

    assign memWrEn = ctrl.memWr;

    assign pcPlus4 = pc + 32'd4;
    assign pcImm   = pc + imm;

    always_comb begin
        case (ctrl.regDataSel)
            wbAlu:   wbData = aluRes;
            wbImm:   wbData = imm;
            wbPcImm: wbData = pcImm;
            default: wbData = pcPlus4;
        endcase
    end

    assign rdWrEn = ctrl.regWr;
    assign rdAddr = instruction[11:7];
    assign rdData = ctrl.memToReg ? ldData : wbData;

    always_comb begin
        if (ctrl.aluToPc) begin
            nextPc = {aluRes[31:1], 1'b0}; // JALR target
        end else if (ctrl.branch) begin
            nextPc = pcImm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (step) begin
            pc <= nextPc;
        end
    end

endmodule

// ==== rvExecTop.sv ====
module rvExecTop #(
    parameter rvIsaPkg::wordT resetPc = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              step,        // Advance the PC on this edge
    input  rvIsaPkg::wordT    instruction,
    input  rvIsaPkg::wordT    rs1Data,
    input  rvIsaPkg::wordT    rs2Data,
    input  rvIsaPkg::wordT    memRdData,
    output rvIsaPkg::wordT    pc,
    output logic              rdWrEn,
    output rvIsaPkg::regIdxT  rdAddr,
    output rvIsaPkg::wordT    rdData,
    output rvIsaPkg::wordT    memAddr,
    output logic              memWrEn,
    output rvCtrlPkg::byteEnT memByteEn,
    output rvIsaPkg::wordT    memWrData
);

    rvIsaPkg::wordT imm;
    logic           aluZero;

    ctrlIf ctrlBus ();

    controller uCtrl (
        .instruction (instruction),
        .aluZero     (aluZero),
        .ctrl        (ctrlBus.ctrlSrc)
    );

    immGen uImm (
        .instruction (instruction),
        .imm         (imm)
    );

    execStage #(
        .resetPc (resetPc)
    ) uExec (
        .clk         (clk),
        .rstN        (rstN),
        .step        (step),
        .instruction (instruction),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .memRdData   (memRdData),
        .imm         (imm),
        .ctrl        (ctrlBus.ctrlSnk),
        .aluZero     (aluZero),
        .pc          (pc),
        .rdWrEn      (rdWrEn),
        .rdAddr      (rdAddr),
        .rdData      (rdData),
        .memAddr     (memAddr),
        .memWrEn     (memWrEn),
        .memByteEn   (memByteEn),
        .memWrData   (memWrData)
    );

endmodule

// ==== rvExecTb.sv ====
module rvExecTb;
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    localparam wordT resetPc   = 32'h0000_0100;
    localparam wordT fenceWord = 32'h0000_000F;
    localparam wordT ecallWord = 32'h0000_0073;

    // Stimulus, expected outputs, check groups and PC after the step of one table row
    typedef struct packed {
        wordT     instr;
        wordT     rs1;
        wordT     rs2;
        wordT     rdMem;
        logic     stp;
        logic     rdWe;
        regIdxT   rdIdx;
        wordT     rd;
        logic     memWe;
        byteEnT   be;
        wordT     wd;
        wordT     addr;
        logic [2:0] chk;   // Bit 0 rdData, bit 1 memAddr, bit 2 store lanes
        wordT     nxt;
    } rowT;

    logic     clk;
    logic     rstN;
    logic     step;
    wordT     instruction;
    wordT     rs1Data;
    wordT     rs2Data;
    wordT     memRdData;
    wordT     pc;
    logic     rdWrEn;
    regIdxT   rdAddr;
    wordT     rdData;
    wordT     memAddr;
    logic     memWrEn;
    byteEnT   memByteEn;
    wordT     memWrData;

    rowT  rows[$];
    wordT modelPc = resetPc;  // PC seen by the row being added
    wordT expPc;
    int   rowIdx = 0;
    int   wordErrs = 0;
    int   byteEnErrs = 0;
    int   bitErrs = 0;
    int   regIdxErrs = 0;
    int   cycles = 0;
    int   cycleLimit = 0;

    rvExecTop #(
        .resetPc (resetPc)
    ) DUT (
        .clk         (clk),
        .rstN        (rstN),
        .step        (step),
        .instruction (instruction),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .memRdData   (memRdData),
        .pc          (pc),
        .rdWrEn      (rdWrEn),
        .rdAddr      (rdAddr),
        .rdData      (rdData),
        .memAddr     (memAddr),
        .memWrEn     (memWrEn),
        .memByteEn   (memByteEn),
        .memWrData   (memWrData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles, the table run did not finish", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic wordT encodeR(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, opOp, 2'b11}; // rs1 = x1, rs2 = x2
    endfunction

    function automatic wordT encodeI(logic [4:0] op, logic [2:0] f3, logic [4:0] rd,
                                     logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op, 2'b11};
    endfunction

    function automatic wordT encodeS(logic [2:0] f3, logic [11:0] imm);
        return {imm[11:5], 5'd4, 5'd3, f3, imm[4:0], opStore, 2'b11};
    endfunction

    function automatic wordT encodeB(logic [2:0] f3, wordT off);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], opBranch, 2'b11};
    endfunction

    function automatic wordT encodeU(logic [4:0] op, logic [4:0] rd, logic [19:0] upper);
        return {upper, rd, op, 2'b11};
    endfunction

    function automatic wordT encodeJ(logic [4:0] rd, wordT off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJal, 2'b11};
    endfunction

    // Branch condition straight from the ISA definition
    function automatic logic branchTaken(logic [2:0] f3, wordT x, wordT y);
        case (f3)
            f3Beq:   return x == y;
            f3Bne:   return x != y;
            f3Blt:   return $signed(x) < $signed(y);
            f3Bge:   return $signed(x) >= $signed(y);
            f3Bltu:  return x < y;
            default: return x >= y;
        endcase
    endfunction

    task automatic addRow(input wordT instr, rs1, rs2, rdMem, input logic stp, rdWe,
                          input regIdxT rdIdx, input wordT rd, input logic memWe,
                          input byteEnT be, input wordT wd, addr, input logic [2:0] chk,
                          input wordT nxt);
        rowT r;
        r = '{instr, rs1, rs2, rdMem, stp, rdWe, rdIdx, rd, memWe, be, wd, addr, chk, nxt};
        rows.push_back(r);
        modelPc = nxt;
    endtask

    task automatic aluRow(input wordT instr, rs1, rs2, exp);
        addRow(instr, rs1, rs2, '0, 1'b1, 1'b1, 5'd5, exp, 1'b0, 4'h0, '0, '0, 3'b001,
               modelPc + 32'd4); // All ALU rows write x5
    endtask

    task automatic loadRow(input wordT instr, rs1, mem, addr, exp);
        addRow(instr, rs1, '0, mem, 1'b1, 1'b1, 5'd6, exp, 1'b0, 4'h0, '0, addr, 3'b011,
               modelPc + 32'd4); // All loads write x6
    endtask

    task automatic storeRow(input wordT instr, rs1, rs2, addr, input byteEnT be,
                            input wordT wd);
        addRow(instr, rs1, rs2, '0, 1'b1, 1'b0, '0, '0, 1'b1, be, wd, addr, 3'b110,
               modelPc + 32'd4);
    endtask

    task automatic ctlRow(input wordT instr, rs1, rs2, input logic stp, rdWe,
                          input regIdxT rdIdx, input wordT rd, nxt);
        addRow(instr, rs1, rs2, '0, stp, rdWe, rdIdx, rd, 1'b0, 4'h0, '0, '0,
               {2'b00, rdWe}, nxt);
    endtask

    task automatic buildTable();
        wordT       a;
        wordT       b;
        wordT       c;
        wordT       memVal;
        wordT       brOff;
        logic [7:0] bt;
        logic [15:0] hw;
        logic       tk;
        logic [2:0] brF3 [6];
        wordT       brA [3];
        wordT       brB [3];
        a      = $urandom;
        b      = $urandom;
        c      = $urandom;
        memVal = 32'h8A7B_C6D5;
        brF3   = '{f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu};
        brA    = '{32'hFFFF_FFFB, 32'd2, 32'd7}; // -5, 2, 7
        brB    = '{32'd2, 32'hFFFF_FFFB, 32'd7};
        aluRow(encodeR(7'h00, 3'b000, 5'd5), a, b, a + b);
        aluRow(encodeR(7'h20, 3'b000, 5'd5), a, b, a - b);
        aluRow(encodeR(7'h00, 3'b001, 5'd5), a, b, a << b[4:0]);
        aluRow(encodeR(7'h00, 3'b010, 5'd5), 32'hFFFF_FFF0, 32'd5, 32'd1);
        aluRow(encodeR(7'h00, 3'b011, 5'd5), 32'hFFFF_FFF0, 32'd5, 32'd0);
        aluRow(encodeR(7'h00, 3'b100, 5'd5), a, b, a ^ b);
        aluRow(encodeR(7'h00, 3'b101, 5'd5), a | 32'h8000_0000, b,
               (a | 32'h8000_0000) >> b[4:0]);
        aluRow(encodeR(7'h20, 3'b101, 5'd5), a | 32'h8000_0000, b,
               $signed(a | 32'h8000_0000) >>> b[4:0]);
        aluRow(encodeR(7'h00, 3'b110, 5'd5), a, b, a | b);
        aluRow(encodeR(7'h00, 3'b111, 5'd5), a, b, a & b);
        aluRow(encodeI(opOpImm, 3'b000, 5'd5, 5'd1, 12'hFFD), a, b, a + 32'hFFFF_FFFD);
        aluRow(encodeI(opOpImm, 3'b010, 5'd5, 5'd1, 12'hFFF), 32'hFFFF_FFF0, b, 32'd1);
        aluRow(encodeI(opOpImm, 3'b011, 5'd5, 5'd1, 12'hFFF), 32'd5, b, 32'd1);
        aluRow(encodeI(opOpImm, 3'b100, 5'd5, 5'd1, 12'h800), a, b, a ^ 32'hFFFF_F800);
        aluRow(encodeI(opOpImm, 3'b110, 5'd5, 5'd1, 12'h0F0), a, b, a | 32'h0000_00F0);
        aluRow(encodeI(opOpImm, 3'b111, 5'd5, 5'd1, 12'hFF0), a, b, a & 32'hFFFF_FFF0);
        aluRow(encodeI(opOpImm, 3'b001, 5'd5, 5'd1, 12'h007), a, b, a << 7);
        aluRow(encodeI(opOpImm, 3'b101, 5'd5, 5'd1, 12'h004), a | 32'h8000_0000, b,
               (a | 32'h8000_0000) >> 4);
        aluRow(encodeI(opOpImm, 3'b101, 5'd5, 5'd1, 12'h404), a | 32'h8000_0000, b,
               $signed(a | 32'h8000_0000) >>> 4);
        // Negative offsets from rs1 reach every lane
        for (int ofs = 0; ofs < 4; ofs++) begin
            bt = memVal[8*ofs +: 8];
            loadRow(encodeI(opLoad, f3Lb, 5'd6, 5'd3, 12'(ofs - 4)), 32'h1004, memVal,
                    32'h1000 + ofs, {{24{bt[7]}}, bt});
            loadRow(encodeI(opLoad, f3Lbu, 5'd6, 5'd3, 12'(ofs - 4)), 32'h1004, memVal,
                    32'h1000 + ofs, {24'b0, bt});
        end
        for (int ofs = 0; ofs < 4; ofs += 2) begin
            hw = memVal[8*ofs +: 16];
            loadRow(encodeI(opLoad, f3Lh, 5'd6, 5'd3, 12'(ofs)), 32'h1000, memVal,
                    32'h1000 + ofs, {{16{hw[15]}}, hw});
            loadRow(encodeI(opLoad, f3Lhu, 5'd6, 5'd3, 12'(ofs)), 32'h1000, memVal,
                    32'h1000 + ofs, {16'b0, hw});
        end
        loadRow(encodeI(opLoad, f3Lw, 5'd6, 5'd3, 12'h000), 32'h1000, memVal, 32'h1000, memVal);
        for (int ofs = 0; ofs < 4; ofs++) begin
            storeRow(encodeS(f3Sb, 12'(ofs - 16)), 32'h2010, c, 32'h2000 + ofs,
                     4'b0001 << ofs, {4{c[7:0]}});
        end
        storeRow(encodeS(f3Sh, 12'h000), 32'h2000, c, 32'h2000, 4'b0011, {2{c[15:0]}});
        storeRow(encodeS(f3Sh, 12'h002), 32'h2000, c, 32'h2002, 4'b1100, {2{c[15:0]}});
        storeRow(encodeS(f3Sw, 12'h004), 32'h2000, c, 32'h2004, 4'b1111, c);
        foreach (brF3[k]) begin
            for (int j = 0; j < 3; j++) begin
                brOff = (j == 1) ? 32'hFFFF_FFF8 : 32'd20;
                tk    = branchTaken(brF3[k], brA[j], brB[j]);
                ctlRow(encodeB(brF3[k], brOff), brA[j], brB[j], 1'b1, 1'b0, '0, '0,
                       tk ? modelPc + brOff : modelPc + 32'd4);
            end
        end
        ctlRow(encodeJ(5'd1, 32'h40), '0, '0, 1'b1, 1'b1, 5'd1, modelPc + 32'd4,
               modelPc + 32'h40);
        ctlRow(encodeI(opJalr, 3'b000, 5'd1, 5'd7, 12'h010), 32'h3001, '0, 1'b1, 1'b1,
               5'd1, modelPc + 32'd4, 32'h3010); // Target 0x3011 loses bit 0
        ctlRow(encodeU(opLui, 5'd2, 20'hABCDE), '0, '0, 1'b1, 1'b1, 5'd2, 32'hABCD_E000,
               modelPc + 32'd4);
        ctlRow(encodeU(opAuipc, 5'd3, 20'h12345), '0, '0, 1'b1, 1'b1, 5'd3,
               modelPc + 32'h1234_5000, modelPc + 32'd4);
        ctlRow(encodeJ(5'd1, 32'hFFFF_FFE0), '0, '0, 1'b1, 1'b1, 5'd1, modelPc + 32'd4,
               modelPc - 32'd32);
        ctlRow(encodeI(opOpImm, 3'b000, 5'd5, 5'd1, 12'h001), a, '0, 1'b0, 1'b1, 5'd5,
               a + 32'd1, modelPc); // PC holds while step is low
        ctlRow(fenceWord, '0, '0, 1'b1, 1'b0, '0, '0, modelPc + 32'd4);
        ctlRow(ecallWord, '0, '0, 1'b1, 1'b0, '0, '0, modelPc + 32'd4);
    endtask

    task automatic checkWord(input string name, input wordT act, input wordT exp);
        if (act !== exp) begin
            wordErrs++;
            $display("ERR %s row %0d: expected %08h, got %08h", name, rowIdx, exp, act);
        end
    endtask

    task automatic checkByteEn(input string name, input byteEnT act, input byteEnT exp);
        if (act !== exp) begin
            byteEnErrs++;
            $display("ERR %s row %0d: expected %h, got %h", name, rowIdx, exp, act);
        end
    endtask

    task automatic checkBit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            bitErrs++;
            $display("ERR %s row %0d: expected %h, got %h", name, rowIdx, exp, act);
        end
    endtask

    task automatic checkRegIdx(input string name, input regIdxT act, input regIdxT exp);
        if (act !== exp) begin
            regIdxErrs++;
            $display("ERR %s row %0d: expected %02h, got %02h", name, rowIdx, exp, act);
        end
    endtask

    initial begin
        rstN        = 1'b0;
        step        = 1'b0;
        instruction = fenceWord; // No write enables during reset
        rs1Data     = '0;
        rs2Data     = '0;
        memRdData   = '0;
        void'($urandom(56));
        buildTable();
        cycleLimit = 16 + 4 * rows.size() + 20;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        expPc = resetPc;
        foreach (rows[i]) begin
            @(posedge clk);
            rowIdx = i;
            instruction <= rows[i].instr;
            rs1Data     <= rows[i].rs1;
            rs2Data     <= rows[i].rs2;
            memRdData   <= rows[i].rdMem;
            step        <= rows[i].stp;
            @(negedge clk);
            checkWord("pc", pc, expPc); // Result of the previous row's step
            checkBit("rdWrEn", rdWrEn, rows[i].rdWe);
            checkBit("memWrEn", memWrEn, rows[i].memWe);
            if (rows[i].rdWe) begin
                checkRegIdx("rdAddr", rdAddr, rows[i].rdIdx);
            end
            if (rows[i].chk[0]) begin
                checkWord("rdData", rdData, rows[i].rd);
            end
            if (rows[i].chk[1]) begin
                checkWord("memAddr", memAddr, rows[i].addr);
            end
            if (rows[i].chk[2]) begin
                checkByteEn("memByteEn", memByteEn, rows[i].be);
                checkWord("memWrData", memWrData, rows[i].wd);
            end
            expPc = rows[i].nxt;
        end
        @(posedge clk);
        rowIdx = rows.size();
        step        <= 1'b0;
        instruction <= fenceWord;
        @(negedge clk);
        checkWord("pc", pc, expPc);
        $display("Errors: %0d word, %0d byte enable, %0d bit, %0d reg index, %0d total",
                 wordErrs, byteEnErrs, bitErrs, regIdxErrs,
                 wordErrs + byteEnErrs + bitErrs + regIdxErrs);
        if (wordErrs + byteEnErrs + bitErrs + regIdxErrs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
rvIsaPkg.sv
rvCtrlPkg.sv
ctrlIf.sv
controller.sv
immGen.sv
execStage.sv
rvExecTop.sv
rvExecTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module rvExecTb \
    --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
